/* design/rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes still decoded
  localparam logic [6:0] op_imm   = 7'b001_0011; // addi
  localparam logic [6:0] op_lui   = 7'b011_0111;
  localparam logic [6:0] op_auipc = 7'b001_0111;
  localparam logic [6:0] op_jal   = 7'b110_1111;
  localparam logic [6:0] op_jalr  = 7'b110_0111;
  localparam logic [6:0] op_load  = 7'b000_0011;
  localparam logic [6:0] op_store = 7'b010_0011;

  // load/store width field
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // data ram geometry
  localparam int dmem_words  = 256;
  localparam int dmem_addr_w = 8;

  // one instruction word, four ways of reading it
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic        imm_20;
      logic [9:0]  imm_10_1;
      logic        imm_11;
      logic [7:0]  imm_19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } j;
  } inst_word_u;

endpackage

/* design/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::inst_word_u             inst,
  output logic [rv_pkg::reg_addr_w-1:0]  rs1,
  output logic [rv_pkg::reg_addr_w-1:0]  rs2,
  output logic [rv_pkg::reg_addr_w-1:0]  rd,
  output logic [2:0]                     funct3,
  output logic [rv_pkg::xlen-1:0]        imm,
  output logic                           use_pc,
  output logic                           link,
  output logic                           is_jump,
  output logic                           is_load,
  output logic                           reg_wen,
  output logic                           mem_read,
  output logic                           mem_write
);
  import rv_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  // sign extended immediates, one per format
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm, 12'h000}; // already shifted
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  assign rs2    = inst.s.rs2;
  assign rd     = inst.i.rd;
  assign funct3 = inst.i.funct3;

  always_comb begin
    rs1       = inst.i.rs1;
    imm       = imm_i;
    use_pc    = 1'b0;
    link      = 1'b0;
    is_jump   = 1'b0;
    is_load   = 1'b0;
    reg_wen   = 1'b0; // unknown opcode has no side effect
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (inst.i.opcode)
      op_imm: reg_wen = 1'b1;
      op_lui: begin
        rs1     = '0; // x0 feeds the adder, so the sum is the immediate
        imm     = imm_u;
        reg_wen = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u;
        use_pc  = 1'b1;
        reg_wen = 1'b1;
      end
      op_jal: begin
        imm     = imm_j;
        use_pc  = 1'b1;
        link    = 1'b1;
        is_jump = 1'b1;
        reg_wen = 1'b1;
      end
      op_jalr: begin
        link    = 1'b1; // rs1 + imm target
        is_jump = 1'b1;
        reg_wen = 1'b1;
      end
      op_load: begin
        is_load  = 1'b1;
        mem_read = 1'b1;
        reg_wen  = 1'b1;
      end
      op_store: begin
        imm       = imm_s;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [rv_pkg::reg_addr_w-1:0]  rs1,
  input  logic [rv_pkg::reg_addr_w-1:0]  rs2,
  input  logic [rv_pkg::reg_addr_w-1:0]  rd,
  input  logic                           wen,
  input  logic [rv_pkg::xlen-1:0]        wdata,
  output logic [rv_pkg::xlen-1:0]        rs1_data,
  output logic [rv_pkg::xlen-1:0]        rs2_data
);
  import rv_pkg::*;

  localparam int num_regs = 1 << reg_addr_w;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < num_regs; r++) begin
        regs[r] <= '0;
      end
    end else if (wen && rd != '0) begin // x0 is hardwired
      regs[rd] <= wdata;
    end
  end

  // regs[0] is cleared by reset and never written
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

/* design/rv_lsu.sv */
`timescale 1ns/10ps

module rv_lsu (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [rv_pkg::xlen-1:0]  addr,
  input  logic [2:0]               funct3,
  input  logic                     mem_read,
  input  logic                     mem_write,
  input  logic [rv_pkg::xlen-1:0]  store_data,
  output logic [rv_pkg::xlen-1:0]  load_data
);
  import rv_pkg::*;

  logic [xlen-1:0]        ram [dmem_words];
  logic [dmem_addr_w-1:0] word_idx;
  logic [1:0]             lane;
  logic [3:0]             byte_mask;
  logic [xlen-1:0]        store_lanes;
  logic [xlen-1:0]        rdata;
  logic [xlen-1:0]        rdata_shifted;
  logic [xlen-1:0]        load_ext;

  assign word_idx = addr[dmem_addr_w+1:2];
  assign lane     = addr[1:0];

  // which byte lanes a store touches
  always_comb begin
    case (funct3)
      f3_byte: byte_mask = 4'b0001 << lane;
      f3_half: byte_mask = lane[1] ? 4'b1100 : 4'b0011;
      f3_word: byte_mask = 4'b1111;
      default: byte_mask = 4'b0000;
    endcase
  end

  // replicate the low bytes so every lane sees its data
  always_comb begin
    case (funct3)
      f3_byte: store_lanes = {4{store_data[7:0]}};
      f3_half: store_lanes = {2{store_data[15:0]}};
      default: store_lanes = store_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_write && !reset) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_mask[b]) begin
          ram[word_idx][8*b +: 8] <= store_lanes[8*b +: 8];
        end
      end
    end
  end

  assign rdata         = ram[word_idx];
  assign rdata_shifted = rdata >> {lane, 3'b000}; // addressed lane down to bit 0

  always_comb begin
    case (funct3)
      f3_byte:   load_ext = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      f3_half:   load_ext = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      f3_byte_u: load_ext = {24'h00_0000, rdata_shifted[7:0]};
      f3_half_u: load_ext = {16'h0000, rdata_shifted[15:0]};
      default:   load_ext = rdata; // lw
    endcase
  end

  assign load_data = mem_read ? load_ext : '0;

  half_aligned: assert property (@(posedge clk) disable iff (reset)
    (mem_read || mem_write) && (funct3 == f3_half || funct3 == f3_half_u)
      |-> !addr[0])
    else $error("misaligned half-word access at %h", addr);

  word_aligned: assert property (@(posedge clk) disable iff (reset)
    (mem_read || mem_write) && funct3 == f3_word |-> addr[1:0] == 2'b00)
    else $error("misaligned word access at %h", addr);

endmodule

/* design/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [rv_pkg::xlen-1:0]        inst,
  output logic [rv_pkg::xlen-1:0]        pc,
  output logic                           wb_en,
  output logic [rv_pkg::reg_addr_w-1:0]  wb_addr,
  output logic [rv_pkg::xlen-1:0]        wb_data
);
  import rv_pkg::*;

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [2:0]            funct3;
  logic [xlen-1:0]       imm;
  logic                  use_pc;
  logic                  link;
  logic                  is_jump;
  logic                  is_load;
  logic                  reg_wen;
  logic                  mem_read;
  logic                  mem_write;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       load_data;
  logic [xlen-1:0]       adder_a;
  logic [xlen-1:0]       addr;
  logic [xlen-1:0]       pc_plus4;
  logic [xlen-1:0]       next_pc;
  logic [xlen-1:0]       wdata;

  rv_decoder u_decoder (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .funct3    (funct3),
    .imm       (imm),
    .use_pc    (use_pc),
    .link      (link),
    .is_jump   (is_jump),
    .is_load   (is_load),
    .reg_wen   (reg_wen),
    .mem_read  (mem_read),
    .mem_write (mem_write)
  );

  // shared adder for addi, lui, auipc, jump targets and memory addresses
  assign adder_a  = use_pc ? pc : rs1_data;
  assign addr     = adder_a + imm;
  assign pc_plus4 = pc + 32'd4;

  assign next_pc = is_jump ? {addr[xlen-1:1], 1'b0} : pc_plus4; // jalr drops bit 0

  always_ff @(posedge clk) begin
    if (reset) pc <= reset_pc;
    else       pc <= next_pc;
  end

  always_comb begin
    if (link)         wdata = pc_plus4; // return address
    else if (is_load) wdata = load_data;
    else              wdata = addr;
  end

  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wen      (reg_wen),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_lsu u_lsu (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .funct3     (funct3),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .store_data (rs2_data),
    .load_data  (load_data)
  );

  // retire port mirrors the register write
  assign wb_en   = reg_wen;
  assign wb_addr = rd;
  assign wb_data = wdata;

endmodule

/* tests/tb_model.svh */
// opcodes for building and modelling programs
localparam logic [6:0] opc_imm   = 7'h13;
localparam logic [6:0] opc_lui   = 7'h37;
localparam logic [6:0] opc_auipc = 7'h17;
localparam logic [6:0] opc_jal   = 7'h6f;
localparam logic [6:0] opc_jalr  = 7'h67;
localparam logic [6:0] opc_load  = 7'h03;
localparam logic [6:0] opc_store = 7'h23;

logic [31:0] model_regs [32];
logic [31:0] model_mem  [256]; // word picked by byte address bits [9:2]
logic [31:0] model_pc;

task automatic model_reset();
  foreach (model_regs[r]) model_regs[r] = '0;
  foreach (model_mem[w]) model_mem[w] = '0;
  model_pc = 32'h8000_0000;
endtask

// retires one instruction on the model, returns the expected write port
function automatic void model_step(input logic [31:0] ins, output logic wen,
                                   output logic [4:0] waddr, output logic [31:0] wdata);
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] ea;
  logic [31:0] word;
  logic [31:0] nxt;
  logic [2:0]  f3;
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_u = {ins[31:12], 12'h000};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  a     = model_regs[ins[19:15]];
  b     = model_regs[ins[24:20]];
  f3    = ins[14:12];
  waddr = ins[11:7];
  wen   = 1'b1; // everything but a store writes rd
  wdata = '0;
  nxt   = model_pc + 32'd4;
  case (ins[6:0])
    opc_imm:   wdata = a + imm_i;
    opc_lui:   wdata = imm_u;
    opc_auipc: wdata = model_pc + imm_u;
    opc_jal: begin
      wdata = model_pc + 32'd4;
      nxt   = model_pc + imm_j;
    end
    opc_jalr: begin
      wdata = model_pc + 32'd4;
      nxt   = (a + imm_i) & ~32'd1; // target bit 0 cleared
    end
    opc_load: begin
      ea   = a + imm_i;
      word = model_mem[ea[9:2]] >> {ea[1:0], 3'b000};
      case (f3)
        3'b000:  wdata = {{24{word[7]}}, word[7:0]};
        3'b001:  wdata = {{16{word[15]}}, word[15:0]};
        3'b100:  wdata = {24'h00_0000, word[7:0]};
        3'b101:  wdata = {16'h0000, word[15:0]};
        default: wdata = word;
      endcase
    end
    opc_store: begin
      wen = 1'b0;
      ea  = a + imm_s;
      case (f3)
        3'b000:  model_mem[ea[9:2]][{ea[1:0], 3'b000} +: 8] = b[7:0];
        3'b001:  model_mem[ea[9:2]][{ea[1], 4'b0000} +: 16] = b[15:0];
        default: model_mem[ea[9:2]] = b;
      endcase
    end
    default: wen = 1'b0;
  endcase
  if (wen && waddr != 5'd0) model_regs[waddr] = wdata;
  model_pc = nxt;
endfunction

/* tests/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;
  localparam int half_period = 50;
  localparam int seed        = 32'h9900;
  localparam int step_limit  = 20; // cycles allowed for one check
  localparam int rand_steps  = 200;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  logic [31:0] prog [$];
  string       names [$];
  logic        pending;
  logic        exp_wen;
  logic [4:0]  exp_addr;
  logic [31:0] exp_data;
  logic [31:0] exp_pc;
  string       exp_name;
  logic        timed_out;
  int          errors;
  int          checks;

  `include "tb_model.svh"

  rv_core_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .inst    (inst),
    .pc      (pc),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  always #half_period clk = ~clk;

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input int rs2, input int rs1,
                                        input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
  endfunction

  task automatic add(input string name, input logic [31:0] word);
    prog.push_back(word);
    names.push_back(name);
  endtask

  // memory ops use x0 as base so they stay aligned inside words 0..15
  task automatic add_random();
    int rd;
    int rs;
    int sel;
    int imm;
    logic [2:0] f3;
    rd = $urandom % 32;
    rs = $urandom % 32;
    case ($urandom % 7)
      0: add("random addi", enc_i(opc_imm, 3'b000, rd, rs, $urandom));
      1: add("random lui", enc_u(opc_lui, rd, $urandom));
      2: add("random auipc", enc_u(opc_auipc, rd, $urandom));
      3: add("random jal", enc_j(rd, $urandom));
      4: add("random jalr", enc_i(opc_jalr, 3'b000, rd, rs, $urandom));
      5: begin
        sel = $urandom % 5;
        f3  = (sel > 2) ? 3'(sel + 1) : 3'(sel); // lb lh lw lbu lhu
        imm = ($urandom % 64) >> f3[1:0] << f3[1:0];
        add("random load", enc_i(opc_load, f3, rd, 0, imm));
      end
      default: begin
        f3  = 3'($urandom % 3);
        imm = ($urandom % 64) >> f3[1:0] << f3[1:0];
        add("random store", enc_s(f3, rs, 0, imm));
      end
    endcase
  endtask

  task automatic build_program();
    add("addi", enc_i(opc_imm, 3'b000, 1, 0, 'h123));
    add("addi negative", enc_i(opc_imm, 3'b000, 2, 1, -5));
    add("lui", enc_u(opc_lui, 3, 'h12345));
    add("auipc", enc_u(opc_auipc, 4, 'hfffff));
    add("addi to x0", enc_i(opc_imm, 3'b000, 0, 1, 77));
    add("read x0", enc_i(opc_imm, 3'b000, 5, 0, 0));
    for (int k = 0; k < 16; k++) begin // defined contents for every word loaded later
      add("fill lui", enc_u(opc_lui, 10, $urandom));
      add("fill addi", enc_i(opc_imm, 3'b000, 10, 10, $urandom));
      add("fill sw", enc_s(3'b010, 10, 0, 4 * k));
    end
    add("sw", enc_s(3'b010, 3, 0, 20));
    add("lw after sw", enc_i(opc_load, 3'b010, 12, 0, 20));
    for (int l = 0; l < 4; l++) begin
      add("byte data", enc_i(opc_imm, 3'b000, 11, 0, $urandom));
      add("sb", enc_s(3'b000, 11, 0, 12 + l));
      add("lb", enc_i(opc_load, 3'b000, 13, 0, 12 + l));
      add("lbu", enc_i(opc_load, 3'b100, 14, 0, 12 + l));
      add("lw after sb", enc_i(opc_load, 3'b010, 15, 0, 12));
    end
    for (int l = 0; l < 4; l += 2) begin
      add("sh", enc_s(3'b001, 10, 0, 12 + l));
      add("lh", enc_i(opc_load, 3'b001, 13, 0, 12 + l));
      add("lhu", enc_i(opc_load, 3'b101, 14, 0, 12 + l));
      add("lw after sh", enc_i(opc_load, 3'b010, 15, 0, 12));
    end
    add("jal", enc_j(1, 'h100));
    add("jal back", enc_j(0, -8));
    add("jalr", enc_i(opc_jalr, 3'b000, 6, 3, 'h7ff)); // odd sum, bit 0 dropped
    for (int n = 0; n < rand_steps; n++) add_random();
  endtask

  task automatic wait_for_check();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > step_limit) begin
        $display("timeout: no check for %s after %0d cycles", exp_name, step_limit);
        errors++;
        timed_out = 1'b1;
        return;
      end
    end while (pending);
  endtask

  // compares the retire port and pc right before the edge that retires
  always @(posedge clk) begin
    if (!reset && pending) begin
      checks++;
      if (pc !== exp_pc) begin
        errors++;
        $display("Fail %s pc expected %h actual %h", exp_name, exp_pc, pc);
      end
      if (wb_en !== exp_wen) begin
        errors++;
        $display("Fail %s wb_en expected %b actual %b", exp_name, exp_wen, wb_en);
      end
      if (exp_wen && wb_addr !== exp_addr) begin
        errors++;
        $display("Fail %s wb_addr expected %0d actual %0d", exp_name, exp_addr, wb_addr);
      end
      if (exp_wen && wb_data !== exp_data) begin
        errors++;
        $display("Fail %s wb_data expected %h actual %h", exp_name, exp_data, wb_data);
      end
      pending = 1'b0;
    end
  end

  initial begin
    void'($urandom(seed));
    reset     = 1'b1;
    inst      = 32'h0000_0013; // nop
    pending   = 1'b0;
    timed_out = 1'b0;
    errors    = 0;
    checks    = 0;
    model_reset();
    build_program();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    foreach (prog[n]) begin
      exp_pc   = model_pc;
      exp_name = names[n];
      model_step(prog[n], exp_wen, exp_addr, exp_data);
      inst    = prog[n];
      pending = 1'b1;
      wait_for_check();
      if (timed_out) break;
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* rv_core.f */
+incdir+tests
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_lsu.sv
design/rv_core_top.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := $(wildcard tests/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
